//--- logic/memPkg.sv
`default_nettype none

package memPkg;

    // byte address space of the shared RAM
    localparam int AddrWidth = 12;

    // word and RAM port widths
    localparam int DataWidth = 32;
    localparam int ByteWidth = 8;

    // first fetch address after reset
    localparam logic [AddrWidth-1:0] ResetPc = '0;

    // access size of one memory request
    typedef enum logic [1:0] {
        SizeByte = 2'd0,
        SizeHalf = 2'd1,
        SizeWord = 2'd2
    } memSize_e;

    // bit positions in the arbiter grant vector
    localparam int ClientData  = 0;
    localparam int ClientFetch = 1;

endpackage

`default_nettype wire

//--- logic/byteRam.sv
`default_nettype none

module byteRam
    import memPkg::*;
(
    input  wire logic                 clk,
    input  wire logic [AddrWidth-1:0] ramAddr,
    input  wire logic                 ramWe,
    input  wire logic [ByteWidth-1:0] ramWdata,
    output logic      [ByteWidth-1:0] ramRdata
);

    logic [ByteWidth-1:0] mem [2**AddrWidth];

    always_ff @(posedge clk) begin
        if (ramWe) begin
            mem[ramAddr] <= ramWdata;
        end
        // read data shows up one cycle after the address
        ramRdata <= mem[ramAddr];
    end

endmodule

`default_nettype wire

//--- logic/memArbiter.sv
`default_nettype none

module memArbiter
    import memPkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 dataReq,
    input  wire logic [AddrWidth-1:0] dataAddr,
    input  wire memSize_e             dataSize,
    input  wire logic                 dataWrite,
    input  wire logic [DataWidth-1:0] dataWdata,
    input  wire logic                 fetchReq,
    input  wire logic [AddrWidth-1:0] fetchAddr,
    output logic                      dataDone,
    output logic                      fetchDone,
    output logic      [DataWidth-1:0] rdata,
    output logic                      seqStart,
    output logic      [AddrWidth-1:0] seqAddr,
    output memSize_e                  seqSize,
    output logic                      seqWrite,
    output logic      [DataWidth-1:0] seqWdata,
    input  wire logic                 seqDone,
    input  wire logic [DataWidth-1:0] seqRdata
);

    logic [1:0] grant;
    logic       startQ;
    logic       idle;

    assign idle = (grant == 2'b00);

    // data client wins when both are waiting
    always_ff @(posedge clk) begin
        if (rst) begin
            grant  <= 2'b00;
            startQ <= 1'b0;
        end else begin
            startQ <= 1'b0;
            if (idle) begin
                if (dataReq) begin
                    grant[ClientData] <= 1'b1;
                    startQ            <= 1'b1;
                end else if (fetchReq) begin
                    grant[ClientFetch] <= 1'b1;
                    startQ             <= 1'b1;
                end
            end else if (seqDone) begin
                grant <= 2'b00;
            end
        end
    end

    assign seqStart = startQ;
    assign seqAddr  = grant[ClientData] ? dataAddr : fetchAddr;
    // fetch is always a word read
    assign seqSize  = grant[ClientData] ? dataSize : SizeWord;
    assign seqWrite = grant[ClientData] & dataWrite;
    assign seqWdata = grant[ClientData] ? dataWdata : '0;

    assign dataDone  = seqDone & grant[ClientData];
    assign fetchDone = seqDone & grant[ClientFetch];
    assign rdata     = seqRdata;

    doneNeedsGrant: assert property (@(posedge clk) disable iff (rst) seqDone |-> !idle);

endmodule

`default_nettype wire

//--- logic/byteSequencer.sv
`default_nettype none

module byteSequencer
    import memPkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 pause,
    input  wire logic                 start,
    input  wire logic [AddrWidth-1:0] addr,
    input  wire memSize_e             size,
    input  wire logic                 write,
    input  wire logic [DataWidth-1:0] wdata,
    output logic                      done,
    output logic      [DataWidth-1:0] rdata,
    output logic      [AddrWidth-1:0] ramAddr,
    output logic                      ramWe,
    output logic      [ByteWidth-1:0] ramWdata,
    input  wire logic [ByteWidth-1:0] ramRdata
);

    logic                 active;
    logic                 writeQ;
    logic [1:0]           lastIdx;
    logic [AddrWidth-1:0] baseAddr;
    logic [DataWidth-1:0] wdataQ;
    logic [DataWidth-1:0] dataQ;
    logic [2:0]           issueCnt;
    logic [1:0]           retCnt;
    logic                 pending;
    logic                 issuing;
    logic [1:0]           byteIdx;
    logic [DataWidth-1:0] merged;

    assign issuing = active && !writeQ && (issueCnt <= {1'b0, lastIdx});

    // while paused, keep re-reading the byte in flight so it is not lost
    assign byteIdx = (pause && pending) ? retCnt : issueCnt[1:0];
    assign ramAddr = baseAddr + AddrWidth'(byteIdx);

    assign ramWe    = active && writeQ && !pause;
    assign ramWdata = wdataQ[ByteWidth-1:0];

    // returned byte k goes to bits 8k+7:8k
    assign merged = dataQ | (DataWidth'(ramRdata) << (ByteWidth * retCnt));
    assign rdata  = (pending && !writeQ) ? merged : dataQ;

    always_comb begin
        done = 1'b0;
        if (active && !pause) begin
            if (writeQ) begin
                done = (issueCnt[1:0] == lastIdx);
            end else begin
                done = pending && (retCnt == lastIdx);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active  <= 1'b0;
            pending <= 1'b0;
        end else if (!active) begin
            if (start) begin
                active   <= 1'b1;
                writeQ   <= write;
                baseAddr <= addr;
                wdataQ   <= wdata;
                dataQ    <= '0;
                issueCnt <= '0;
                retCnt   <= '0;
                pending  <= 1'b0;
                case (size)
                    SizeByte: lastIdx <= 2'd0;
                    SizeHalf: lastIdx <= 2'd1;
                    default:  lastIdx <= 2'd3;
                endcase
            end
        end else if (!pause) begin
            if (done) begin
                active  <= 1'b0;
                pending <= 1'b0;
            end else if (writeQ) begin
                // next byte to the low lane
                issueCnt <= issueCnt + 3'd1;
                wdataQ   <= wdataQ >> ByteWidth;
            end else begin
                pending <= issuing;
                if (issuing) begin
                    issueCnt <= issueCnt + 3'd1;
                end
                if (pending) begin
                    retCnt <= retCnt + 2'd1;
                    dataQ  <= merged;
                end
            end
        end
    end

    noStartWhileActive: assert property (@(posedge clk) disable iff (rst) start |-> !active);

endmodule

`default_nettype wire

//--- logic/instFetch.sv
`default_nettype none

module instFetch
    import memPkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 fetchEn,
    input  wire logic                 redirect,
    input  wire logic [AddrWidth-1:0] redirectPc,
    output logic                      fetchReq,
    output logic      [AddrWidth-1:0] fetchAddr,
    input  wire logic                 fetchDone,
    input  wire logic [DataWidth-1:0] rdata,
    output logic                      instValid,
    output logic      [DataWidth-1:0] inst,
    output logic      [AddrWidth-1:0] instPc
);

    logic [AddrWidth-1:0] pc;
    // fetch in flight was overtaken by a redirect
    logic                 discard;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= ResetPc;
            fetchReq  <= 1'b0;
            discard   <= 1'b0;
            instValid <= 1'b0;
        end else begin
            instValid <= 1'b0;
            if (fetchReq) begin
                if (fetchDone) begin
                    fetchReq <= 1'b0;
                    discard  <= 1'b0;
                    if (!discard && !redirect) begin
                        instValid <= 1'b1;
                        inst      <= rdata;
                        instPc    <= fetchAddr;
                        pc        <= fetchAddr + AddrWidth'(4);
                    end
                end else if (redirect) begin
                    discard <= 1'b1;
                end
            end else if (fetchEn && !redirect) begin
                fetchReq  <= 1'b1;
                fetchAddr <= pc;
            end
            // redirect overrides any pc step
            if (redirect) begin
                pc <= redirectPc;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/loadStore.sv
`default_nettype none

module loadStore
    import memPkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 lsEn,
    input  wire logic                 lsWrite,
    input  wire memSize_e             lsSize,
    input  wire logic                 lsSigned,
    input  wire logic [AddrWidth-1:0] lsAddr,
    input  wire logic [DataWidth-1:0] lsWdata,
    output logic                      lsBusy,
    output logic                      dataReq,
    output logic      [AddrWidth-1:0] dataAddr,
    output memSize_e                  dataSize,
    output logic                      dataWrite,
    output logic      [DataWidth-1:0] dataWdata,
    input  wire logic                 dataDone,
    input  wire logic [DataWidth-1:0] rdata,
    output logic                      lsDone,
    output logic      [DataWidth-1:0] lsRdata
);

    logic                 signedQ;
    logic [DataWidth-1:0] loadExt;

    assign dataReq = lsBusy;

    // sign or zero extend by access size
    always_comb begin
        case (dataSize)
            SizeByte: loadExt = {{(DataWidth-8){signedQ & rdata[7]}}, rdata[7:0]};
            SizeHalf: loadExt = {{(DataWidth-16){signedQ & rdata[15]}}, rdata[15:0]};
            default:  loadExt = rdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lsBusy <= 1'b0;
            lsDone <= 1'b0;
        end else begin
            lsDone <= 1'b0;
            if (!lsBusy) begin
                if (lsEn) begin
                    lsBusy    <= 1'b1;
                    dataAddr  <= lsAddr;
                    dataSize  <= lsSize;
                    dataWrite <= lsWrite;
                    dataWdata <= lsWdata;
                    signedQ   <= lsSigned;
                end
            end else if (dataDone) begin
                lsBusy  <= 1'b0;
                lsDone  <= 1'b1;
                lsRdata <= dataWrite ? '0 : loadExt;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/memSubsystem.sv
`default_nettype none

module memSubsystem
    import memPkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 pause,
    input  wire logic                 fetchEn,
    input  wire logic                 redirect,
    input  wire logic [AddrWidth-1:0] redirectPc,
    output logic                      instValid,
    output logic      [DataWidth-1:0] inst,
    output logic      [AddrWidth-1:0] instPc,
    input  wire logic                 lsEn,
    input  wire logic                 lsWrite,
    input  wire memSize_e             lsSize,
    input  wire logic                 lsSigned,
    input  wire logic [AddrWidth-1:0] lsAddr,
    input  wire logic [DataWidth-1:0] lsWdata,
    output logic                      lsBusy,
    output logic                      lsDone,
    output logic      [DataWidth-1:0] lsRdata
);

    logic                 fetchReq;
    logic [AddrWidth-1:0] fetchAddr;
    logic                 fetchDone;
    logic                 dataReq;
    logic [AddrWidth-1:0] dataAddr;
    memSize_e             dataSize;
    logic                 dataWrite;
    logic [DataWidth-1:0] dataWdata;
    logic                 dataDone;
    logic [DataWidth-1:0] clientRdata;

    logic                 seqStart;
    logic [AddrWidth-1:0] seqAddr;
    memSize_e             seqSize;
    logic                 seqWrite;
    logic [DataWidth-1:0] seqWdata;
    logic                 seqDone;
    logic [DataWidth-1:0] seqRdata;

    logic [AddrWidth-1:0] ramAddr;
    logic                 ramWe;
    logic [ByteWidth-1:0] ramWdata;
    logic [ByteWidth-1:0] ramRdata;

    instFetch instFetch_i (
        .clk        (clk),
        .rst        (rst),
        .fetchEn    (fetchEn),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .fetchReq   (fetchReq),
        .fetchAddr  (fetchAddr),
        .fetchDone  (fetchDone),
        .rdata      (clientRdata),
        .instValid  (instValid),
        .inst       (inst),
        .instPc     (instPc)
    );

    loadStore loadStore_i (
        .clk       (clk),
        .rst       (rst),
        .lsEn      (lsEn),
        .lsWrite   (lsWrite),
        .lsSize    (lsSize),
        .lsSigned  (lsSigned),
        .lsAddr    (lsAddr),
        .lsWdata   (lsWdata),
        .lsBusy    (lsBusy),
        .dataReq   (dataReq),
        .dataAddr  (dataAddr),
        .dataSize  (dataSize),
        .dataWrite (dataWrite),
        .dataWdata (dataWdata),
        .dataDone  (dataDone),
        .rdata     (clientRdata),
        .lsDone    (lsDone),
        .lsRdata   (lsRdata)
    );

    memArbiter memArbiter_i (
        .clk       (clk),
        .rst       (rst),
        .dataReq   (dataReq),
        .dataAddr  (dataAddr),
        .dataSize  (dataSize),
        .dataWrite (dataWrite),
        .dataWdata (dataWdata),
        .fetchReq  (fetchReq),
        .fetchAddr (fetchAddr),
        .dataDone  (dataDone),
        .fetchDone (fetchDone),
        .rdata     (clientRdata),
        .seqStart  (seqStart),
        .seqAddr   (seqAddr),
        .seqSize   (seqSize),
        .seqWrite  (seqWrite),
        .seqWdata  (seqWdata),
        .seqDone   (seqDone),
        .seqRdata  (seqRdata)
    );

    byteSequencer byteSequencer_i (
        .clk      (clk),
        .rst      (rst),
        .pause    (pause),
        .start    (seqStart),
        .addr     (seqAddr),
        .size     (seqSize),
        .write    (seqWrite),
        .wdata    (seqWdata),
        .done     (seqDone),
        .rdata    (seqRdata),
        .ramAddr  (ramAddr),
        .ramWe    (ramWe),
        .ramWdata (ramWdata),
        .ramRdata (ramRdata)
    );

    byteRam byteRam_i (
        .clk      (clk),
        .ramAddr  (ramAddr),
        .ramWe    (ramWe),
        .ramWdata (ramWdata),
        .ramRdata (ramRdata)
    );

endmodule

`default_nettype wire

//--- verification/memSubsystemTb.sv
`default_nettype none

module memSubsystemTb
    import memPkg::*;
();

    localparam int PreloadOps = 128;
    localparam int LoadOps = 40;
    localparam int PartialOps = 30;
    localparam int FetchOps = 24;
    localparam int MixedOps = 80;
    localparam int PauseBudget = 400;
    localparam int NumOps = PreloadOps + LoadOps + 2 * PartialOps + FetchOps + MixedOps + 8;
    localparam int TimeoutCycles = NumOps * 40 + PauseBudget + 8;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 pause;
    logic                 fetchEn;
    logic                 redirect;
    logic [AddrWidth-1:0] redirectPc;
    logic                 instValid;
    logic [DataWidth-1:0] inst;
    logic [AddrWidth-1:0] instPc;
    logic                 lsEn;
    logic                 lsWrite;
    memSize_e             lsSize;
    logic                 lsSigned;
    logic [AddrWidth-1:0] lsAddr;
    logic [DataWidth-1:0] lsWdata;
    logic                 lsBusy;
    logic                 lsDone;
    logic [DataWidth-1:0] lsRdata;

    // reference byte image of the RAM
    logic [ByteWidth-1:0] model [2**AddrWidth];
    logic [AddrWidth-1:0] expPc;
    logic [DataWidth-1:0] expLs;
    logic                 lsPending;
    logic                 pauseEn;
    int                   pauseUsed;
    int                   instCount;
    int                   instBefore;
    int                   errors;
    int                   checks;

    memSubsystem memSubsystem_i (.*);

    always #5 clk = ~clk;

    // little endian read with extension by size
    function automatic logic [DataWidth-1:0] modelLoad(input logic [AddrWidth-1:0] addr,
                                                       input memSize_e size, input logic sgn);
        logic [DataWidth-1:0] word;
        word = {model[addr + 12'd3], model[addr + 12'd2], model[addr + 12'd1], model[addr]};
        case (size)
            SizeByte: return {{24{sgn & word[7]}}, word[7:0]};
            SizeHalf: return {{16{sgn & word[15]}}, word[15:0]};
            default:  return word;
        endcase
    endfunction

    task automatic modelStore(input logic [AddrWidth-1:0] addr, input memSize_e size,
                              input logic [DataWidth-1:0] data);
        int n;
        n = (size == SizeByte) ? 1 : (size == SizeHalf) ? 2 : 4;
        for (int k = 0; k < n; k++) begin
            model[addr + AddrWidth'(k)] = data[8*k +: 8];
        end
    endtask

    // load/store area lies apart from the fetched code
    function automatic logic [AddrWidth-1:0] alignedAddr(input memSize_e size);
        logic [AddrWidth-1:0] addr;
        addr = 12'd256 + 12'($urandom % 256);
        if (size == SizeHalf) begin
            addr[0] = 1'b0;
        end else if (size == SizeWord) begin
            addr[1:0] = 2'b00;
        end
        return addr;
    endfunction

    function automatic logic [AddrWidth-1:0] randomFetchPc();
        return 12'($urandom % 32) * 12'd4;
    endfunction

    // check outputs at the falling edge and drive pause
    task automatic tick();
        @(negedge clk);
        if (pause && (lsDone || instValid)) begin
            $display("done pulse at %0t although pause was high", $time);
            errors++;
        end
        if (instValid) begin
            checks++;
            instCount++;
            if (instPc !== expPc) begin
                $display("FAILED at %0t: instPc got %h expected %h", $time, instPc, expPc);
                errors++;
            end
            if (inst !== modelLoad(expPc, SizeWord, 1'b0)) begin
                $display("FAILED at %0t: inst got %h expected %h", $time, inst,
                         modelLoad(expPc, SizeWord, 1'b0));
                errors++;
            end
            expPc = expPc + 12'd4;
        end
        if (lsDone) begin
            checks++;
            if (!lsPending) begin
                $display("lsDone at %0t without an outstanding command", $time);
                errors++;
            end else if (lsRdata !== expLs) begin
                $display("FAILED at %0t: lsRdata got %h expected %h", $time, lsRdata, expLs);
                errors++;
            end
            lsPending = 1'b0;
        end
        pause = 1'b0;
        if (pauseEn && pauseUsed < PauseBudget && ($urandom % 4) == 0) begin
            pause = 1'b1;
            pauseUsed++;
        end
    endtask

    task automatic accessLs(input logic wr, input memSize_e size, input logic sgn,
                            input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] wdata);
        lsWrite  = wr;
        lsSize   = size;
        lsSigned = sgn;
        lsAddr   = addr;
        lsWdata  = wdata;
        if (wr) begin
            expLs = '0;
            modelStore(addr, size, wdata);
        end else begin
            expLs = modelLoad(addr, size, sgn);
        end
        lsEn      = 1'b1;
        lsPending = 1'b1;
        tick();
        lsEn = 1'b0;
        // command was captured at the last rising edge
        checks++;
        if (lsBusy !== 1'b1) begin
            $display("FAILED at %0t: lsBusy got %b expected %b", $time, lsBusy, 1'b1);
            errors++;
        end
        while (lsPending) begin
            tick();
        end
    endtask

    task automatic randomLs();
        memSize_e size;
        size = memSize_e'(2'($urandom % 3));
        accessLs(1'($urandom % 2), size, 1'($urandom % 2), alignedAddr(size), $urandom);
    endtask

    task automatic pulseRedirect(input logic [AddrWidth-1:0] pc);
        redirectPc = pc;
        redirect   = 1'b1;
        expPc      = pc;
        tick();
        redirect = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h702d));
        rst = 1'b1;
        pause = 1'b0;
        fetchEn = 1'b0;
        redirect = 1'b0;
        redirectPc = '0;
        lsEn = 1'b0;
        lsWrite = 1'b0;
        lsSize = SizeWord;
        lsSigned = 1'b0;
        lsAddr = '0;
        lsWdata = '0;
        expPc = ResetPc;
        lsPending = 1'b0;
        pauseEn = 1'b0;
        pauseUsed = 0;
        instCount = 0;
        errors = 0;
        checks = 0;
        repeat (8) tick();
        rst = 1'b0;
        if (lsBusy !== 1'b0 || lsDone !== 1'b0 || instValid !== 1'b0) begin
            $display("outputs not low after reset at %0t", $time);
            errors++;
        end

        // word preload of code and data areas
        for (int i = 0; i < PreloadOps; i++) begin
            accessLs(1'b1, SizeWord, 1'b0, 12'(4 * i), $urandom);
        end
        for (int i = 0; i < LoadOps; i++) begin
            if (i % 5 == 0) begin
                accessLs(1'b1, SizeWord, 1'b0, alignedAddr(SizeWord), $urandom);
            end else begin
                lsSize = memSize_e'(2'(i % 3));
                accessLs(1'b0, lsSize, 1'(i % 2), alignedAddr(lsSize), '0);
            end
        end
        // partial stores read back as whole words
        for (int i = 0; i < PartialOps; i++) begin
            lsSize = (i % 2 == 1) ? SizeHalf : SizeByte;
            lsAddr = alignedAddr(lsSize);
            accessLs(1'b1, lsSize, 1'b0, lsAddr, $urandom);
            accessLs(1'b0, SizeWord, 1'b0, {lsAddr[AddrWidth-1:2], 2'b00}, '0);
        end

        fetchEn = 1'b1;
        while (instCount < FetchOps / 2) begin
            tick();
        end
        // redirect while the next word is in flight
        instBefore = instCount;
        while (instCount == instBefore) begin
            tick();
        end
        repeat (2) tick();
        pulseRedirect(randomFetchPc());
        while (instCount < FetchOps) begin
            tick();
        end

        // data goes first when both clients ask in the same cycle
        fetchEn = 1'b0;
        repeat (20) tick();
        instBefore = instCount;
        fetchEn = 1'b1;
        accessLs(1'b0, SizeWord, 1'b0, alignedAddr(SizeWord), '0);
        if (instCount != instBefore) begin
            $display("instruction delivered before the competing load at %0t", $time);
            errors++;
        end

        for (int i = 0; i < MixedOps; i++) begin
            pauseEn = (i >= MixedOps / 2);
            if (i % 4 == 0) begin
                pulseRedirect(randomFetchPc());
            end
            randomLs();
        end
        pauseEn = 1'b0;
        fetchEn = 1'b0;
        repeat (20) tick();

        $display("checks: %0d, errors: %0d, instructions: %0d, pause cycles: %0d",
                 checks, errors, instCount, pauseUsed);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(TimeoutCycles * 10);
        $display("watchdog expired after %0d cycles waiting for a done pulse", TimeoutCycles);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
logic/memPkg.sv
logic/byteRam.sv
logic/memArbiter.sv
logic/byteSequencer.sv
logic/instFetch.sv
logic/loadStore.sv
logic/memSubsystem.sv
verification/memSubsystemTb.sv

//--- run.sh
#!/bin/sh
# build and run the memSubsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module memSubsystemTb -o memSubsystemTb
./obj_dir/memSubsystemTb > sim.log 2>&1 || true
cat sim.log

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
exit 0
